// File: bench/tb_periph.sv
/*
  Directed testbench for the APB peripheral subsystem.
  Inputs change on falling edges, and APB read data is sampled 1 ns later.
  Stops at the first error, and a cycle counter bounds the whole run.
*/
`timescale 1ns/1ps

module tb_periph;
    import periph_pkg::*;

    localparam int TimeoutCycles = 4000;
    localparam int NumRegs       = 10;

    logic     clk;
    logic     rst_n;
    logic     psel;
    logic     penable;
    logic     pwrite;
    addr_t    paddr;
    word_t    pwdata;
    word_t    prdata;
    logic     pslverr;
    irq_vec_t irq;

    int       cycle_cnt;
    int       done_cycle;
    int       sample_cycle;
    addr_t    reg_list [NumRegs];
    word_t    reg_mask [NumRegs];
    word_t    shadow [NumRegs];

    periph_top i_periph_top (
        .clk_i     ( clk     ),
        .rst_n_i   ( rst_n   ),
        .psel_i    ( psel    ),
        .penable_i ( penable ),
        .pwrite_i  ( pwrite  ),
        .paddr_i   ( paddr   ),
        .pwdata_i  ( pwdata  ),
        .prdata_o  ( prdata  ),
        .pslverr_o ( pslverr ),
        .irq_o     ( irq     )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TimeoutCycles) begin
            abort_run("Timeout: the run went past its cycle limit");
        end
    end

    // ------------------------------
    // Error handling and compares
    // ------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_irq(input string name, input irq_vec_t exp, input irq_vec_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    // Byte address of a register word: slot in [11:8], word index in [7:2]
    function automatic addr_t reg_addr(input int slot, input reg_offset_t ofs);
        return addr_t'({slot[3:0], ofs, 2'b00});
    endfunction

    // ------------------------------
    // APB access tasks
    // ------------------------------
    task automatic apb_write(input addr_t addr, input word_t data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        err = pslverr;
        @(posedge clk);
        @(negedge clk);
        psel       = 1'b0;
        penable    = 1'b0;
        done_cycle = cycle_cnt;
    endtask

    task automatic apb_read(input addr_t addr, output word_t data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data         = prdata;
        err          = pslverr;
        sample_cycle = cycle_cnt;
        @(posedge clk);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_ok(input addr_t addr, input word_t data);
        logic err;
        apb_write(addr, data, err);
        check_bit("pslverr_o", 1'b0, err);
    endtask

    task automatic read_expect(input string name, input addr_t addr, input word_t exp);
        word_t data;
        logic  err;
        apb_read(addr, data, err);
        check_bit("pslverr_o", 1'b0, err);
        check_word(name, exp, data);
    endtask

    task automatic wait_irq(input int target, input logic level, input int max_cycles);
        int n;
        n = 0;
        while (irq[target] !== level) begin
            if (n == max_cycles) begin
                abort_run($sformatf("irq_o[%0d] did not go to %0b in %0d cycles",
                                    target, level, max_cycles));
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic expect_irq_for(input irq_vec_t exp, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_irq("irq_o", exp, irq);
        end
    endtask

    task automatic build_reg_list();
        for (int t = 0; t < NumTimers; t++) begin
            reg_list[2*t]   = reg_addr(t, TimerCountOfs);
            reg_list[2*t+1] = reg_addr(t, TimerCmpOfs);
            reg_mask[2*t]   = '1;
            reg_mask[2*t+1] = '1;
        end
        for (int i = 0; i < 2; i++) begin
            reg_list[4+i] = reg_addr(PlicSlot, reg_offset_t'(PlicPrioOfs + i + 1));
            reg_list[6+i] = reg_addr(PlicSlot, reg_offset_t'(PlicEnableOfs + i));
            reg_list[8+i] = reg_addr(PlicSlot, reg_offset_t'(PlicThreshOfs + i));
            reg_mask[4+i] = word_t'(MaxPriority);
            reg_mask[6+i] = word_t'((1 << NumSources) - 1);
            reg_mask[8+i] = word_t'(MaxPriority);
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_reset_state();
        check_irq("irq_o", '0, irq);
        check_bit("pslverr_o", 1'b0, pslverr);
        for (int t = 0; t < NumTimers; t++) begin
            read_expect("timer CTRL", reg_addr(t, TimerCtrlOfs), '0);
            read_expect("timer COUNT", reg_addr(t, TimerCountOfs), '0);
            read_expect("timer COMPARE", reg_addr(t, TimerCmpOfs), '0);
        end
        read_expect("PLIC PENDING", reg_addr(PlicSlot, PlicPendOfs), '0);
        for (int i = 6; i < NumRegs; i++) begin
            read_expect("PLIC enable/threshold", reg_list[i], '0);
        end
    endtask

    task automatic test_readback();
        word_t w;
        for (int i = 0; i < NumRegs; i++) begin
            w = $urandom();
            write_ok(reg_list[i], w);
            shadow[i] = w & reg_mask[i];
            read_expect("register readback", reg_list[i], shadow[i]);
        end
    endtask

    task automatic test_bus_decode();
        word_t data;
        logic  err;
        for (int s = PlicSlot + 1; s < NumSlots; s++) begin
            apb_read(reg_addr(s, reg_offset_t'($urandom_range(63, 0))), data, err);
            check_bit("pslverr_o", 1'b1, err);
            check_word("prdata_o", ErrorWord, data);
            // Same offsets as the mapped registers, only the slot differs
            for (int i = 0; i < NumRegs; i++) begin
                apb_write(addr_t'({s[3:0], reg_list[i][7:0]}), $urandom(), err);
                check_bit("pslverr_o", 1'b1, err);
            end
        end
        for (int i = 0; i < NumRegs; i++) begin
            read_expect("register after unmapped writes", reg_list[i], shadow[i]);
        end
    endtask

    task automatic test_counting();
        word_t data;
        logic  err;
        for (int t = 0; t < NumTimers; t++) begin
            write_ok(reg_addr(t, TimerCountOfs), '0);
            write_ok(reg_addr(t, TimerCmpOfs), 32'hffff_0000);
            write_ok(reg_addr(t, TimerCtrlOfs), 32'd1);
            repeat (5 + t) @(negedge clk);
            apb_read(reg_addr(t, TimerCountOfs), data, err);
            check_bit("pslverr_o", 1'b0, err);
            check_word("timer COUNT", word_t'(sample_cycle - done_cycle), data);
            write_ok(reg_addr(t, TimerCtrlOfs), '0);
        end
    endtask

    task automatic test_irq_flow();
        write_ok(reg_addr(PlicSlot, reg_offset_t'(PlicPrioOfs + 1)), 32'd3);
        write_ok(reg_addr(PlicSlot, reg_offset_t'(PlicPrioOfs + 2)), '0);
        write_ok(reg_addr(PlicSlot, PlicEnableOfs), 32'd1);
        write_ok(reg_addr(PlicSlot, reg_offset_t'(PlicEnableOfs + 1)), '0);
        write_ok(reg_addr(PlicSlot, PlicThreshOfs), '0);
        read_expect("PLIC PENDING", reg_addr(PlicSlot, PlicPendOfs), '0);

        write_ok(reg_addr(0, TimerCountOfs), '0);
        write_ok(reg_addr(0, TimerCmpOfs), 32'd5);
        write_ok(reg_addr(0, TimerCtrlOfs), 32'd1);
        wait_irq(0, 1'b1, 50);
        check_irq("irq_o", 2'b01, irq);
        read_expect("PLIC PENDING", reg_addr(PlicSlot, PlicPendOfs), 32'd1);
        read_expect("PLIC CLAIM 0", reg_addr(PlicSlot, PlicClaimOfs), 32'd1);

        // Timer keeps pulsing, but source 1 is in service
        wait_irq(0, 1'b0, 4);
        expect_irq_for(2'b00, 30);
        read_expect("PLIC PENDING", reg_addr(PlicSlot, PlicPendOfs), '0);

        write_ok(reg_addr(PlicSlot, PlicClaimOfs), 32'd1);
        wait_irq(0, 1'b1, 20);
        write_ok(reg_addr(0, TimerCtrlOfs), '0);
        repeat (5) @(negedge clk);
        read_expect("PLIC CLAIM 0", reg_addr(PlicSlot, PlicClaimOfs), 32'd1);
        write_ok(reg_addr(PlicSlot, PlicClaimOfs), 32'd1);
        read_expect("PLIC PENDING", reg_addr(PlicSlot, PlicPendOfs), '0);
    endtask

    task automatic test_priority();
        write_ok(reg_addr(PlicSlot, reg_offset_t'(PlicPrioOfs + 1)), 32'd2);
        write_ok(reg_addr(PlicSlot, reg_offset_t'(PlicPrioOfs + 2)), 32'd5);
        write_ok(reg_addr(PlicSlot, PlicEnableOfs), 32'd3);
        for (int t = 0; t < NumTimers; t++) begin
            write_ok(reg_addr(t, TimerCountOfs), '0);
            write_ok(reg_addr(t, TimerCmpOfs), 32'd3);
            write_ok(reg_addr(t, TimerCtrlOfs), 32'd1);
        end
        repeat (20) @(negedge clk);
        for (int t = 0; t < NumTimers; t++) begin
            write_ok(reg_addr(t, TimerCtrlOfs), '0);
        end
        repeat (5) @(negedge clk);
        read_expect("PLIC PENDING", reg_addr(PlicSlot, PlicPendOfs), 32'd3);
        wait_irq(0, 1'b1, 5);
        check_irq("irq_o", 2'b01, irq);

        // Threshold equal to the best priority masks the target
        write_ok(reg_addr(PlicSlot, PlicThreshOfs), 32'd5);
        wait_irq(0, 1'b0, 4);
        expect_irq_for(2'b00, 10);
        read_expect("PLIC PENDING", reg_addr(PlicSlot, PlicPendOfs), 32'd3);

        write_ok(reg_addr(PlicSlot, PlicThreshOfs), '0);
        wait_irq(0, 1'b1, 4);
        read_expect("PLIC CLAIM 0", reg_addr(PlicSlot, PlicClaimOfs), 32'd2);
        read_expect("PLIC CLAIM 0", reg_addr(PlicSlot, PlicClaimOfs), 32'd1);
        read_expect("PLIC PENDING", reg_addr(PlicSlot, PlicPendOfs), '0);
        write_ok(reg_addr(PlicSlot, PlicClaimOfs), 32'd2);
        write_ok(reg_addr(PlicSlot, PlicClaimOfs), 32'd1);
        wait_irq(0, 1'b0, 4);
        check_irq("irq_o", 2'b00, irq);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        void'($urandom(32'h920d_e1c6));
        cycle_cnt    = 0;
        done_cycle   = 0;
        sample_cycle = 0;
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        build_reg_list();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_readback();
        test_bus_decode();
        test_counting();
        test_irq_flow();
        test_priority();

        $display("TEST OK");
        $finish;
    end

endmodule

// File: project.f
verilog/periph_pkg.sv
verilog/periph_reg_if.sv
verilog/apb_reg_bridge.sv
verilog/apb_timer_slice.sv
verilog/irq_plic.sv
verilog/periph_top.sv
bench/tb_periph.sv

// File: verilog/apb_reg_bridge.sv
/*
  Zero wait state APB slave, fully combinational.
  Slots above PlicSlot answer with pslverr and ErrorWord, writes there are dropped.
  Clock and reset only feed the protocol checks.
*/
`timescale 1ns/1ps

module apb_reg_bridge (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  periph_pkg::addr_t paddr_i,
    input  periph_pkg::word_t pwdata_i,
    output periph_pkg::word_t prdata_o,
    output logic              pslverr_o,
    periph_reg_if.bridge      bus
);
    import periph_pkg::*;

    logic [AddrWidth-SlotLsb-1:0] slot;
    logic                         mapped;
    logic                         access;
    word_t                        rd_word;

    assign slot   = paddr_i[AddrWidth-1:SlotLsb];
    assign mapped = (slot <= PlicSlot);
    assign access = psel_i && penable_i;

    assign bus.write  = pwrite_i;
    assign bus.offset = paddr_i[SlotLsb-1:2];
    assign bus.wdata  = pwdata_i;

    // Slot strobe only in the access phase
    always_comb begin
        bus.sel = '0;
        if (access && mapped) begin
            bus.sel = slot_sel_t'(1) << slot;
        end
    end

    // Read return, only mapped rdata elements are looked at
    always_comb begin
        rd_word = ErrorWord;
        if (mapped) begin
            rd_word = '0;
            for (int i = 0; i <= PlicSlot; i++) begin
                if (slot == i) begin
                    rd_word = bus.rdata[i];
                end
            end
        end
    end

    assign prdata_o  = rd_word;
    assign pslverr_o = access && !mapped;

    // ------------------------------
    // APB protocol checks
    // ------------------------------
    assert property (@(posedge clk_i) disable iff (!rst_n_i) penable_i |-> psel_i);

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (psel_i && !penable_i) ##1 (psel_i && penable_i) |-> $stable(paddr_i));

endmodule

// File: verilog/apb_timer_slice.sv
/*
  Free running 32 bit timer with compare match, one per register slot.
  On a match the count restarts at 0 and irq_o pulses for one cycle.
  Compare must stay nonzero while counting, else irq_o is no longer a pulse.
*/
`timescale 1ns/1ps

module apb_timer_slice #(
    parameter int Slot = 0
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    periph_reg_if.slot bus,
    output logic       irq_o
);
    import periph_pkg::*;

    logic  en_q;
    word_t count_q;
    word_t cmp_q;
    logic  irq_q;

    logic  wr_en;
    logic  count_wr;
    logic  match;
    word_t rd_word;

    assign wr_en    = bus.sel[Slot] && bus.write;
    assign count_wr = wr_en && (bus.offset == TimerCountOfs);
    assign match    = (count_q == cmp_q);

    // ------------------------------
    // Registers and counter
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q    <= 1'b0;
            count_q <= '0;
            cmp_q   <= '0;
            irq_q   <= 1'b0;
        end else begin
            if (wr_en && bus.offset == TimerCtrlOfs) begin
                en_q <= bus.wdata[0];
            end
            if (wr_en && bus.offset == TimerCmpOfs) begin
                cmp_q <= bus.wdata;
            end

            // Bus write wins over counting
            if (count_wr) begin
                count_q <= bus.wdata;
            end else if (en_q) begin
                count_q <= match ? '0 : count_q + 1'b1;
            end

            // Pulse in the cycle after a match
            irq_q <= en_q && match && !count_wr;
        end
    end

    // Readback, unused offsets read 0
    always_comb begin
        case (bus.offset)
            TimerCtrlOfs:  rd_word = word_t'(en_q);
            TimerCountOfs: rd_word = count_q;
            TimerCmpOfs:   rd_word = cmp_q;
            default:       rd_word = '0;
        endcase
    end

    assign bus.rdata[Slot] = rd_word;
    assign irq_o           = irq_q;

    assert property (@(posedge clk_i) disable iff (!rst_n_i) irq_o |=> !irq_o);

endmodule

// File: verilog/irq_plic.sv
/*
  Reduced PLIC with edge gateways only; a pulse while in service is lost.
  Priority 0 never interrupts, ties go to the lowest source id.
  A claim read returns 0 when nothing is eligible; writing the id back completes it.
  Target lines are registered, one cycle behind the register state.
*/
`timescale 1ns/1ps

module irq_plic (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    periph_reg_if.slot           bus,
    input  periph_pkg::src_vec_t src_i,
    output periph_pkg::irq_vec_t irq_o
);
    import periph_pkg::*;

    prio_t    prio_q [NumSources];
    src_vec_t enable_q [NumTargets];
    prio_t    thresh_q [NumTargets];
    src_vec_t pending_q;
    src_vec_t in_service_q;
    irq_vec_t irq_q;

    prio_t    best_prio [NumTargets];
    src_id_t  best_id [NumTargets];
    logic     acc_rd;
    logic     acc_wr;
    logic     claim_hit;
    src_id_t  claim_id;
    src_vec_t claim_mask;
    src_vec_t complete_mask;
    word_t    rd_word;

    assign acc_rd = bus.sel[PlicSlot] && !bus.write;
    assign acc_wr = bus.sel[PlicSlot] && bus.write;

    // ------------------------------
    // Per-target arbitration
    // ------------------------------
    always_comb begin
        for (int t = 0; t < NumTargets; t++) begin
            best_prio[t] = '0;
            best_id[t]   = '0;
            for (int s = 0; s < NumSources; s++) begin
                if (pending_q[s] && enable_q[t][s] && prio_q[s] > best_prio[t]) begin
                    best_prio[t] = prio_q[s];
                    best_id[t]   = src_id_t'(s + 1);
                end
            end
        end
    end

    // Claim and complete decode
    always_comb begin
        claim_hit     = 1'b0;
        claim_id      = '0;
        complete_mask = '0;
        for (int t = 0; t < NumTargets; t++) begin
            if (bus.offset == PlicClaimOfs + t) begin
                claim_hit = acc_rd;
                claim_id  = best_id[t];
                for (int s = 0; s < NumSources; s++) begin
                    if (acc_wr && bus.wdata == word_t'(s + 1)) begin
                        complete_mask[s] = 1'b1;
                    end
                end
            end
        end
        for (int s = 0; s < NumSources; s++) begin
            claim_mask[s] = claim_hit && (claim_id == src_id_t'(s + 1));
        end
    end

    // Register readback
    always_comb begin
        rd_word = '0;
        for (int s = 0; s < NumSources; s++) begin
            if (bus.offset == PlicPrioOfs + s + 1) begin
                rd_word = word_t'(prio_q[s]);
            end
        end
        if (bus.offset == PlicPendOfs) begin
            rd_word = word_t'(pending_q);
        end
        for (int t = 0; t < NumTargets; t++) begin
            if (bus.offset == PlicEnableOfs + t) begin
                rd_word = word_t'(enable_q[t]);
            end
            if (bus.offset == PlicThreshOfs + t) begin
                rd_word = word_t'(thresh_q[t]);
            end
            if (bus.offset == PlicClaimOfs + t) begin
                rd_word = word_t'(best_id[t]);
            end
        end
    end

    assign bus.rdata[PlicSlot] = rd_word;

    // ------------------------------
    // State
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q    <= '0;
            in_service_q <= '0;
            irq_q        <= '0;
            for (int s = 0; s < NumSources; s++) begin
                prio_q[s] <= '0;
            end
            for (int t = 0; t < NumTargets; t++) begin
                enable_q[t] <= '0;
                thresh_q[t] <= '0;
            end
        end else begin
            // Gateway: new edges only for sources not in service
            pending_q    <= (pending_q | (src_i & ~in_service_q)) & ~claim_mask;
            in_service_q <= (in_service_q | claim_mask) & ~complete_mask;

            for (int s = 0; s < NumSources; s++) begin
                if (acc_wr && bus.offset == PlicPrioOfs + s + 1) begin
                    prio_q[s] <= bus.wdata[$bits(prio_t)-1:0];
                end
            end
            for (int t = 0; t < NumTargets; t++) begin
                if (acc_wr && bus.offset == PlicEnableOfs + t) begin
                    enable_q[t] <= bus.wdata[NumSources-1:0];
                end
                if (acc_wr && bus.offset == PlicThreshOfs + t) begin
                    thresh_q[t] <= bus.wdata[$bits(prio_t)-1:0];
                end
                irq_q[t] <= (best_prio[t] > thresh_q[t]);
            end
        end
    end

    assign irq_o = irq_q;

endmodule

// File: verilog/periph_pkg.sv
/*
  Shared constants and width types of the APB peripheral subsystem.
  Slot field is paddr[11:8], word offset is paddr[7:2]; byte lanes are ignored.
  Timers sit in slots 0..NumTimers-1, the PLIC right after them.
  PLIC source id n (1-based) is timer n-1; id 0 means no source.
*/
package periph_pkg;

    // ------------------------------
    // Bus geometry
    // ------------------------------
    localparam int DataWidth = 32;
    localparam int AddrWidth = 12;
    localparam int SlotLsb   = 8;
    localparam int NumSlots  = 16;

    typedef logic [DataWidth-1:0] word_t;
    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [NumSlots-1:0]  slot_sel_t;
    typedef logic [SlotLsb-3:0]   reg_offset_t;

    // Read data returned by slots without a peripheral
    localparam word_t ErrorWord = 32'hdead_beef;

    // ------------------------------
    // Slot map and interrupt sizing
    // ------------------------------
    localparam int NumTimers   = 2;
    localparam int PlicSlot    = NumTimers;
    localparam int NumSources  = NumTimers;
    localparam int NumTargets  = 2;
    localparam int MaxPriority = 7;

    typedef logic [$clog2(NumSources+1)-1:0]  src_id_t;
    typedef logic [$clog2(MaxPriority+1)-1:0] prio_t;
    typedef logic [NumSources-1:0]            src_vec_t;
    typedef logic [NumTargets-1:0]            irq_vec_t;

    // Timer word offsets, CTRL bit 0 enables counting
    localparam reg_offset_t TimerCtrlOfs  = 6'd0;
    localparam reg_offset_t TimerCountOfs = 6'd1;
    localparam reg_offset_t TimerCmpOfs   = 6'd2;

    // PLIC word offsets, per-source or per-target index is added on top
    localparam reg_offset_t PlicPrioOfs   = 6'd0;
    localparam reg_offset_t PlicPendOfs   = 6'd8;
    localparam reg_offset_t PlicEnableOfs = 6'd16;
    localparam reg_offset_t PlicThreshOfs = 6'd24;
    localparam reg_offset_t PlicClaimOfs  = 6'd32;

endpackage

// File: verilog/periph_reg_if.sv
/*
  Decoded register access from the APB bridge to the peripheral slots.
  sel is one-hot only during the APB access cycle of a mapped slot.
  Each slot drives only its own rdata element; unmapped elements stay open.
*/
`timescale 1ns/1ps

interface periph_reg_if;
    import periph_pkg::*;

    slot_sel_t   sel;
    logic        write;
    reg_offset_t offset;
    word_t       wdata;
    word_t       rdata [NumSlots];

    modport bridge (
        output sel,
        output write,
        output offset,
        output wdata,
        input  rdata
    );

    modport slot (
        input  sel,
        input  write,
        input  offset,
        input  wdata,
        output rdata
    );

endinterface

// File: verilog/periph_top.sv
/*
  Peripheral subsystem top with a plain APB slave port.
  Zero wait states, so there is no pready output.
  irq_o carries one line per PLIC target.
*/
`timescale 1ns/1ps

module periph_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  periph_pkg::addr_t    paddr_i,
    input  periph_pkg::word_t    pwdata_i,
    output periph_pkg::word_t    prdata_o,
    output logic                 pslverr_o,
    output periph_pkg::irq_vec_t irq_o
);
    import periph_pkg::*;

    src_vec_t timer_irq;

    periph_reg_if i_reg_if ();

    // ------------------------------
    // APB decode
    // ------------------------------
    apb_reg_bridge i_bridge (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .prdata_o  ( prdata_o  ),
        .pslverr_o ( pslverr_o ),
        .bus       ( i_reg_if  )
    );

    // Timer n feeds PLIC source n+1
    for (genvar i = 0; i < NumTimers; i++) begin : gen_timer
        apb_timer_slice #(
            .Slot ( i )
        ) i_timer (
            .clk_i   ( clk_i        ),
            .rst_n_i ( rst_n_i      ),
            .bus     ( i_reg_if     ),
            .irq_o   ( timer_irq[i] )
        );
    end

    irq_plic i_plic (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .bus     ( i_reg_if  ),
        .src_i   ( timer_irq ),
        .irq_o   ( irq_o     )
    );

endmodule
